//--- rv_core.f
rtl/rv_core_pkg.sv
rtl/fetch_if.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/bypass_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/rv_core.sv
bench/tb_clock.sv
bench/rv_core_checker.sv
bench/rv_core_sva.sv
bench/rv_core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f
	out="$$(./obj_dir/Vrv_core_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- bench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
	localparam rv_core_pkg::word_t RESET_PC = 32'h8000_0000;
	localparam int NUM = 20;
	localparam int MEM_WORDS = 64;

	logic clock;
	logic rst_i;
	logic inst_req_o;
	rv_core_pkg::word_t inst_addr_o;
	logic inst_ready_i;
	logic inst_rvalid_i;
	rv_core_pkg::word_t inst_data_i;
	logic retire_valid_o;
	rv_core_pkg::word_t retire_pc_o;
	logic retire_we_o;
	rv_core_pkg::reg_addr_t retire_rd_o;
	rv_core_pkg::word_t retire_data_o;
	logic halt_o;

	rv_core_pkg::word_t tbl_inst [NUM];
	logic tbl_we [NUM];
	rv_core_pkg::reg_addr_t tbl_rd [NUM];
	rv_core_pkg::word_t tbl_data [NUM];
	rv_core_pkg::word_t imem [MEM_WORDS];
	logic [31:0] rng_state = 32'hac92_6490;
	logic mem_timeout = 1'b0;
	int tests_passed;
	int tests_failed;

	tb_clock #(.RESET_CYCLES(10)) clock_gen_i (.clock_o(clock), .rst_o(rst_i));

	rv_core #(.RESET_PC(RESET_PC)) rv_core_i (.*);

	rv_core_checker #(.NUM(NUM), .RESET_PC(RESET_PC)) result_check_i (
		.clock(clock), .rst_i(rst_i), .retire_valid_i(retire_valid_o),
		.retire_pc_i(retire_pc_o), .retire_we_i(retire_we_o), .retire_rd_i(retire_rd_o),
		.retire_data_i(retire_data_o), .halt_i(halt_o),
		.exp_we_i(tbl_we), .exp_rd_i(tbl_rd), .exp_data_i(tbl_data)
	);

	function automatic rv_core_pkg::word_t enc_imm(input logic [11:0] imm,
		input rv_core_pkg::reg_addr_t rs1, input logic [2:0] f3,
		input rv_core_pkg::reg_addr_t rd);
		return {imm, rs1, f3, rd, rv_core_pkg::opc_op_imm};
	endfunction

	function automatic rv_core_pkg::word_t enc_reg(input logic [6:0] f7,
		input rv_core_pkg::reg_addr_t rs2, input rv_core_pkg::reg_addr_t rs1,
		input logic [2:0] f3, input rv_core_pkg::reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, rv_core_pkg::opc_op};
	endfunction

	function automatic rv_core_pkg::word_t enc_lui(input logic [19:0] imm,
		input rv_core_pkg::reg_addr_t rd);
		return {imm, rd, rv_core_pkg::opc_lui};
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// words outside the program read as a pattern of their address
	function automatic rv_core_pkg::word_t fetch_word(input rv_core_pkg::word_t addr);
		rv_core_pkg::word_t off;
		off = addr - RESET_PC;
		if (off[1:0] == 2'b00 && off < 32'(MEM_WORDS * 4)) begin
			return imem[off[7:2]];
		end
		return addr ^ 32'h5a5a_a5a5;
	endfunction

	task automatic set_entry(input int i, input rv_core_pkg::word_t inst, input logic we,
		input rv_core_pkg::reg_addr_t rd, input rv_core_pkg::word_t data);
		tbl_inst[i] = inst;
		tbl_we[i] = we;
		tbl_rd[i] = rd;
		tbl_data[i] = data;
	endtask

	// instruction memory model, one request at a time
	initial begin
		int n;
		bit got;
		int lat;
		rv_core_pkg::word_t addr;
		inst_ready_i = 1'b0;
		inst_rvalid_i = 1'b0;
		inst_data_i = '0;
		addr = '0;
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (rst_i && n < 100);
		#1 inst_ready_i = 1'b1;
		while (!halt_o && !mem_timeout) begin
			got = 1'b0;
			n = 0;
			while (!got && !halt_o && n < 100) begin
				@(posedge clock);
				if (inst_req_o && inst_ready_i) begin
					got = 1'b1;
					addr = inst_addr_o;
				end else begin
					// random stalls on the request port
					rng_state = xorshift32(rng_state);
					#1 inst_ready_i = (rng_state[3:2] != 2'b00);
				end
				n++;
			end
			if (got) begin
				rng_state = xorshift32(rng_state);
				lat = int'(rng_state[1:0]) + 1;
				repeat (lat - 1) @(posedge clock);
				#1 inst_rvalid_i = 1'b1;
				inst_data_i = fetch_word(addr);
				@(posedge clock);
				#1 inst_rvalid_i = 1'b0;
			end else if (!halt_o) begin
				$display("timeout: no instruction request within 100 cycles");
				mem_timeout = 1'b1;
			end
		end
	end

	initial begin
		int n;
		set_entry(0, enc_imm(12'h005, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, 32'h0000_0005);
		set_entry(1, enc_imm(12'hffd, 5'd0, 3'b000, 5'd2), 1'b1, 5'd2, 32'hffff_fffd);
		set_entry(2, enc_lui(20'h12345, 5'd3), 1'b1, 5'd3, 32'h1234_5000);
		set_entry(3, enc_imm(12'h678, 5'd3, 3'b000, 5'd3), 1'b1, 5'd3, 32'h1234_5678);
		// srai and srli on a negative value
		set_entry(4, enc_imm(12'h401, 5'd2, 3'b101, 5'd4), 1'b1, 5'd4, 32'hffff_fffe);
		set_entry(5, enc_imm(12'h01c, 5'd2, 3'b101, 5'd5), 1'b1, 5'd5, 32'h0000_000f);
		set_entry(6, enc_imm(12'h004, 5'd1, 3'b001, 5'd6), 1'b1, 5'd6, 32'h0000_0050);
		set_entry(7, enc_imm(12'hfff, 5'd1, 3'b100, 5'd7), 1'b1, 5'd7, 32'hffff_fffa);
		set_entry(8, enc_imm(12'h0a0, 5'd1, 3'b110, 5'd8), 1'b1, 5'd8, 32'h0000_00a5);
		set_entry(9, enc_imm(12'h0ff, 5'd3, 3'b111, 5'd9), 1'b1, 5'd9, 32'h0000_0078);
		set_entry(10, enc_imm(12'h000, 5'd2, 3'b010, 5'd10), 1'b1, 5'd10, 32'h0000_0001);
		set_entry(11, enc_imm(12'hfff, 5'd1, 3'b011, 5'd11), 1'b1, 5'd11, 32'h0000_0001);
		// dependent chain
		set_entry(12, enc_reg(7'h20, 5'd2, 5'd1, 3'b000, 5'd12), 1'b1, 5'd12, 32'h0000_0008);
		set_entry(13, enc_reg(7'h00, 5'd1, 5'd12, 3'b010, 5'd13), 1'b1, 5'd13, 32'h0000_0000);
		set_entry(14, enc_reg(7'h00, 5'd2, 5'd1, 3'b011, 5'd14), 1'b1, 5'd14, 32'h0000_0001);
		set_entry(15, enc_reg(7'h20, 5'd14, 5'd2, 3'b101, 5'd15), 1'b1, 5'd15, 32'hffff_fffe);
		set_entry(16, enc_reg(7'h00, 5'd12, 5'd15, 3'b100, 5'd16), 1'b1, 5'd16, 32'hffff_fff6);
		set_entry(17, enc_reg(7'h00, 5'd1, 5'd1, 3'b000, 5'd0), 1'b1, 5'd0, 32'h0000_000a);
		set_entry(18, enc_reg(7'h00, 5'd3, 5'd0, 3'b000, 5'd17), 1'b1, 5'd17, 32'h1234_5678);
		set_entry(19, rv_core_pkg::ebreak_inst, 1'b0, 5'd0, 32'h0000_0000);
		for (int i = 0; i < MEM_WORDS; i++) begin
			if (i < NUM) begin
				imem[i] = tbl_inst[i];
			end else begin
				imem[i] = (RESET_PC + (32'(i) << 2)) ^ 32'h5a5a_a5a5;
			end
		end
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (rst_i && n < 100);
		n = 0;
		while (!halt_o && !mem_timeout && n < 2000) begin
			@(posedge clock);
			n++;
		end
		if (!halt_o) begin
			$display("timeout: halt_o did not rise");
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			// quiet window after halt
			for (n = 0; n < 30; n++) begin
				@(posedge clock);
			end
			result_check_i.finish_tests(tests_passed, tests_failed);
			$display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
			if (tests_failed == 0 && !mem_timeout) begin
				$display("TESTBENCH PASSED");
			end else begin
				$display("TESTBENCH FAILED");
			end
			$finish;
		end
	end

endmodule

//--- bench/rv_core_sva.sv
`timescale 1ns/1ps

module rv_core_sva (
	input logic               clock,
	input logic               rst_i,
	input logic               inst_req_o,
	input logic               inst_ready_i,
	input rv_core_pkg::word_t inst_addr_o,
	input logic               retire_valid_o,
	input logic               halt_o
);

	addr_stable: assert property (@(posedge clock) disable iff (rst_i)
		inst_req_o && !inst_ready_i |=> $stable(inst_addr_o))
		else $error("inst_addr_o changed while a request was pending");

	no_retire_after_halt: assert property (@(posedge clock) disable iff (rst_i)
		halt_o |=> !retire_valid_o)
		else $error("retire_valid_o asserted after halt_o");

	halt_sticky: assert property (@(posedge clock) disable iff (rst_i)
		halt_o |=> halt_o)
		else $error("halt_o fell after being set");

endmodule

bind rv_core rv_core_sva sva_i (
	.clock          (clock),
	.rst_i          (rst_i),
	.inst_req_o     (inst_req_o),
	.inst_ready_i   (inst_ready_i),
	.inst_addr_o    (inst_addr_o),
	.retire_valid_o (retire_valid_o),
	.halt_o         (halt_o)
);

//--- bench/rv_core_checker.sv
`timescale 1ns/1ps

module rv_core_checker #(
	parameter int NUM = 20,
	parameter rv_core_pkg::word_t RESET_PC = 32'h8000_0000
) (
	input logic                   clock,
	input logic                   rst_i,
	input logic                   retire_valid_i,
	input rv_core_pkg::word_t     retire_pc_i,
	input logic                   retire_we_i,
	input rv_core_pkg::reg_addr_t retire_rd_i,
	input rv_core_pkg::word_t     retire_data_i,
	input logic                   halt_i,
	input logic                   exp_we_i [NUM],
	input rv_core_pkg::reg_addr_t exp_rd_i [NUM],
	input rv_core_pkg::word_t     exp_data_i [NUM]
);
	int idx = 0;
	int late_retires = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int group_err [7];
	bit reported [7];
	bit halt_with_ebreak = 1'b0;

	initial begin
		for (int t = 0; t < 7; t++) begin
			group_err[t] = 0;
			reported[t] = 1'b0;
		end
	end

	// table entries map onto the behaviors they exercise
	function automatic int group_of(input int i);
		if (i <= 11) begin
			return 2;
		end
		if (i <= 16) begin
			return 3;
		end
		if (i <= 18) begin
			return 4;
		end
		return 6;
	endfunction

	task automatic report(input int t, input string name);
		reported[t] = 1'b1;
		if (group_err[t] == 0) begin
			tests_passed++;
			$display("test %0d %s: passed", t, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", t, name, group_err[t]);
		end
	endtask

	task automatic check_entry(input int i);
		int g;
		rv_core_pkg::word_t exp_pc;
		g = group_of(i);
		exp_pc = RESET_PC + (32'(i) << 2);
		if (retire_pc_i !== exp_pc) begin
			$display("Fail retire_pc_o entry %0d: expected %h got %h", i, exp_pc, retire_pc_i);
			group_err[1]++;
			group_err[5]++;
		end
		if (retire_we_i !== exp_we_i[i]) begin
			$display("Fail retire_we_o entry %0d: expected %h got %h", i, exp_we_i[i],
				retire_we_i);
			group_err[g]++;
			group_err[5]++;
		end
		if (retire_rd_i !== exp_rd_i[i]) begin
			$display("Fail retire_rd_o entry %0d: expected %h got %h", i, exp_rd_i[i],
				retire_rd_i);
			group_err[g]++;
			group_err[5]++;
		end
		// data only matters for writing instructions
		if (exp_we_i[i] && retire_data_i !== exp_data_i[i]) begin
			$display("Fail retire_data_o entry %0d: expected %h got %h", i, exp_data_i[i],
				retire_data_i);
			group_err[g]++;
			group_err[5]++;
		end
	endtask

	always @(posedge clock) begin
		if (!rst_i && retire_valid_i) begin
			if (idx >= NUM) begin
				late_retires++;
				$display("unexpected retire after the last instruction, pc %h", retire_pc_i);
			end else begin
				check_entry(idx);
				if (idx == NUM - 1) begin
					halt_with_ebreak = halt_i;
				end
			end
			if (idx == 11) begin
				report(2, "immediate ALU and LUI");
			end
			if (idx == 16) begin
				report(3, "dependent register ops");
			end
			if (idx == 18) begin
				report(4, "x0 writes and reads");
			end
			idx++;
		end
	end

	// called once by the testbench after the quiet window
	task automatic finish_tests(output int passed, output int failed);
		if (idx < NUM) begin
			$display("only %0d of %0d instructions retired", idx, NUM);
			group_err[1]++;
			group_err[5]++;
			group_err[6]++;
		end
		for (int t = 2; t <= 4; t++) begin
			if (!reported[t]) begin
				group_err[t]++;
				report(t, "never completed");
			end
		end
		if (!halt_with_ebreak) begin
			$display("halt_o did not rise together with the EBREAK retire");
			group_err[6]++;
		end
		if (late_retires != 0) begin
			$display("instructions kept retiring after the core halted");
			group_err[6]++;
		end
		report(1, "retire pc order");
		report(5, "sequence under random latency");
		report(6, "ebreak halts the core");
		passed = tests_passed;
		failed = tests_failed;
	endtask

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int RESET_CYCLES = 10
) (
	output logic clock_o,
	output logic rst_o
);
	logic clock_q = 1'b0;
	logic rst_q = 1'b1;

	assign clock_o = clock_q;
	assign rst_o = rst_q;

	// 10 ns period
	initial begin
		forever #5 clock_q = ~clock_q;
	end

	initial begin
		repeat (RESET_CYCLES) @(posedge clock_q);
		#1 rst_q = 1'b0;
	end

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
	parameter rv_core_pkg::word_t RESET_PC = 32'h8000_0000
) (
	input  logic                   clock,
	input  logic                   rst_i,
	output logic                   inst_req_o,
	output rv_core_pkg::word_t     inst_addr_o,
	input  logic                   inst_ready_i,
	input  logic                   inst_rvalid_i,
	input  rv_core_pkg::word_t     inst_data_i,
	output logic                   retire_valid_o,
	output rv_core_pkg::word_t     retire_pc_o,
	output logic                   retire_we_o,
	output rv_core_pkg::reg_addr_t retire_rd_o,
	output rv_core_pkg::word_t     retire_data_o,
	output logic                   halt_o
);
	rv_core_pkg::reg_addr_t rs1;
	rv_core_pkg::reg_addr_t rs2;
	rv_core_pkg::word_t rf1;
	rv_core_pkg::word_t rf2;
	rv_core_pkg::word_t rs1_data;
	rv_core_pkg::word_t rs2_data;
	rv_core_pkg::issue_t issue;
	logic issue_valid;
	rv_core_pkg::word_t ex_result;
	rv_core_pkg::retire_t retire;

	fetch_if fetch_bus ();

	fetch_unit #(
		.RESET_PC (RESET_PC)
	) u_fetch_unit (
		.clock         (clock),
		.rst_i         (rst_i),
		.inst_ready_i  (inst_ready_i),
		.inst_rvalid_i (inst_rvalid_i),
		.inst_data_i   (inst_data_i),
		.inst_req_o    (inst_req_o),
		.inst_addr_o   (inst_addr_o),
		.fetch         (fetch_bus)
	);

	decode_unit u_decode_unit (
		.clock         (clock),
		.rst_i         (rst_i),
		.rs1_data_i    (rs1_data),
		.rs2_data_i    (rs2_data),
		.rs1_o         (rs1),
		.rs2_o         (rs2),
		.issue_o       (issue),
		.issue_valid_o (issue_valid),
		.halt_o        (halt_o),
		.fetch         (fetch_bus)
	);

	register_file u_register_file (
		.clock      (clock),
		.rst_i      (rst_i),
		.raddr1_i   (rs1),
		.raddr2_i   (rs2),
		.wr_i       (retire),
		.wr_valid_i (retire_valid_o),
		.rdata1_o   (rf1),
		.rdata2_o   (rf2)
	);

	bypass_unit u_bypass_unit (
		.rs1_i          (rs1),
		.rs2_i          (rs2),
		.rf1_i          (rf1),
		.rf2_i          (rf2),
		.ex_issue_i     (issue),
		.ex_valid_i     (issue_valid),
		.ex_result_i    (ex_result),
		.retire_i       (retire),
		.retire_valid_i (retire_valid_o),
		.rs1_data_o     (rs1_data),
		.rs2_data_o     (rs2_data)
	);

	execute_unit u_execute_unit (
		.clock          (clock),
		.rst_i          (rst_i),
		.issue_i        (issue),
		.issue_valid_i  (issue_valid),
		.ex_result_o    (ex_result),
		.retire_o       (retire),
		.retire_valid_o (retire_valid_o),
		.retire_pc_o    (retire_pc_o)
	);

	// commit trace
	assign retire_we_o = retire.we;
	assign retire_rd_o = retire.rd;
	assign retire_data_o = retire.data;

endmodule

//--- rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  logic                 clock,
	input  logic                 rst_i,
	input  rv_core_pkg::issue_t  issue_i,
	input  logic                 issue_valid_i,
	output rv_core_pkg::word_t   ex_result_o,
	output rv_core_pkg::retire_t retire_o,
	output logic                 retire_valid_o,
	output rv_core_pkg::word_t   retire_pc_o
);
	rv_core_pkg::word_t result;
	rv_core_pkg::word_t op_a;
	rv_core_pkg::word_t op_b;
	logic [4:0] shamt;
	rv_core_pkg::retire_t retire_q;
	rv_core_pkg::word_t retire_pc_q;
	logic retire_valid_q;

	assign op_a = issue_i.a;
	assign op_b = issue_i.b;
	assign shamt = op_b[4:0];

	always_comb begin
		case (issue_i.op)
			rv_core_pkg::alu_add: result = op_a + op_b;
			rv_core_pkg::alu_sub: result = op_a - op_b;
			rv_core_pkg::alu_sll: result = op_a << shamt;
			rv_core_pkg::alu_slt: result = {31'b0, $signed(op_a) < $signed(op_b)};
			rv_core_pkg::alu_sltu: result = {31'b0, op_a < op_b};
			rv_core_pkg::alu_xor: result = op_a ^ op_b;
			rv_core_pkg::alu_srl: result = op_a >> shamt;
			rv_core_pkg::alu_sra: result = $signed(op_a) >>> shamt;
			rv_core_pkg::alu_or: result = op_a | op_b;
			rv_core_pkg::alu_and: result = op_a & op_b;
			default: result = op_b;
		endcase
	end

	assign ex_result_o = result;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			retire_valid_q <= 1'b0;
		end else begin
			retire_valid_q <= issue_valid_i;
		end
	end

	// retire stage payload
	always_ff @(posedge clock) begin
		retire_q.we <= issue_i.we && !issue_i.ebreak;
		retire_q.rd <= issue_i.rd;
		retire_q.data <= result;
		retire_pc_q <= issue_i.pc;
	end

	assign retire_o = retire_q;
	assign retire_valid_o = retire_valid_q;
	assign retire_pc_o = retire_pc_q;

endmodule

//--- rtl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
	input  logic                   clock,
	input  logic                   rst_i,
	input  rv_core_pkg::word_t     rs1_data_i,
	input  rv_core_pkg::word_t     rs2_data_i,
	output rv_core_pkg::reg_addr_t rs1_o,
	output rv_core_pkg::reg_addr_t rs2_o,
	output rv_core_pkg::issue_t    issue_o,
	output logic                   issue_valid_o,
	output logic                   halt_o,
	fetch_if.consumer              fetch
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic alt_ok;
	logic op_legal;
	logic imm_legal;
	logic take;
	logic stop_q;
	logic halt_q;
	logic issue_valid_q;
	rv_core_pkg::alu_op_e alu_op;
	rv_core_pkg::issue_t issue_d;
	rv_core_pkg::issue_t issue_q;

	assign opcode = fetch.inst[6:0];
	assign funct3 = fetch.inst[14:12];
	assign funct7 = fetch.inst[31:25];
	assign rs1_o = fetch.inst[19:15];
	assign rs2_o = fetch.inst[24:20];

	// nothing more is taken once ebreak is in
	assign fetch.ready = !stop_q;
	assign take = fetch.valid && !stop_q;

	// funct7 = 0100000 only legal on add/sub and the right shifts
	assign alt_ok = (funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101);
	assign op_legal = (funct7 == 7'b0) || alt_ok;
	assign imm_legal = (funct3 != 3'b001 && funct3 != 3'b101) || op_legal;

	always_comb begin
		case (funct3)
			3'b000: alu_op = (opcode == rv_core_pkg::opc_op && funct7[5]) ?
				rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
			3'b001: alu_op = rv_core_pkg::alu_sll;
			3'b010: alu_op = rv_core_pkg::alu_slt;
			3'b011: alu_op = rv_core_pkg::alu_sltu;
			3'b100: alu_op = rv_core_pkg::alu_xor;
			3'b101: alu_op = funct7[5] ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
			3'b110: alu_op = rv_core_pkg::alu_or;
			default: alu_op = rv_core_pkg::alu_and;
		endcase
	end

	// unknown encodings fall through as a no-write pass_b
	always_comb begin
		issue_d.pc = fetch.pc;
		issue_d.op = rv_core_pkg::alu_pass_b;
		issue_d.a = rs1_data_i;
		issue_d.b = rs2_data_i;
		issue_d.rd = fetch.inst[11:7];
		issue_d.we = 1'b0;
		issue_d.ebreak = 1'b0;
		case (opcode)
			rv_core_pkg::opc_op: begin
				issue_d.op = alu_op;
				issue_d.we = op_legal;
			end
			rv_core_pkg::opc_op_imm: begin
				issue_d.op = alu_op;
				issue_d.b = {{20{fetch.inst[31]}}, fetch.inst[31:20]};
				issue_d.we = imm_legal;
			end
			rv_core_pkg::opc_lui: begin
				issue_d.b = {fetch.inst[31:12], 12'b0};
				issue_d.we = 1'b1;
			end
			rv_core_pkg::opc_system: begin
				issue_d.ebreak = (fetch.inst == rv_core_pkg::ebreak_inst);
			end
			default: begin
				issue_d.we = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			stop_q <= 1'b0;
			halt_q <= 1'b0;
			issue_valid_q <= 1'b0;
		end else begin
			issue_valid_q <= take;
			// halt lags one cycle so it rises with the ebreak retire
			halt_q <= stop_q;
			if (take && issue_d.ebreak) begin
				stop_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			issue_q <= issue_d;
		end
	end

	assign issue_o = issue_q;
	assign issue_valid_o = issue_valid_q;
	assign halt_o = halt_q;

endmodule

//--- rtl/bypass_unit.sv
`timescale 1ns/1ps

module bypass_unit (
	input  rv_core_pkg::reg_addr_t rs1_i,
	input  rv_core_pkg::reg_addr_t rs2_i,
	input  rv_core_pkg::word_t     rf1_i,
	input  rv_core_pkg::word_t     rf2_i,
	input  rv_core_pkg::issue_t    ex_issue_i,
	input  logic                   ex_valid_i,
	input  rv_core_pkg::word_t     ex_result_i,
	input  rv_core_pkg::retire_t   retire_i,
	input  logic                   retire_valid_i,
	output rv_core_pkg::word_t     rs1_data_o,
	output rv_core_pkg::word_t     rs2_data_o
);

	// youngest producer wins, execute before retire
	function automatic rv_core_pkg::word_t pick(
		input rv_core_pkg::reg_addr_t rs,
		input rv_core_pkg::word_t rf_data
	);
		if (rs != 5'd0 && ex_valid_i && ex_issue_i.we && ex_issue_i.rd == rs) begin
			return ex_result_i;
		end
		if (rs != 5'd0 && retire_valid_i && retire_i.we && retire_i.rd == rs) begin
			return retire_i.data;
		end
		return rf_data;
	endfunction

	always_comb begin
		rs1_data_o = pick(rs1_i, rf1_i);
		rs2_data_o = pick(rs2_i, rf2_i);
	end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                   clock,
	input  logic                   rst_i,
	input  rv_core_pkg::reg_addr_t raddr1_i,
	input  rv_core_pkg::reg_addr_t raddr2_i,
	input  rv_core_pkg::retire_t   wr_i,
	input  logic                   wr_valid_i,
	output rv_core_pkg::word_t     rdata1_o,
	output rv_core_pkg::word_t     rdata2_o
);
	// x0 has no storage
	rv_core_pkg::word_t regs [31:1];

	assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

	always_ff @(posedge clock) begin
		if (rst_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_valid_i && wr_i.we && wr_i.rd != 5'd0) begin
			regs[wr_i.rd] <= wr_i.data;
		end
	end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter rv_core_pkg::word_t RESET_PC = 32'h8000_0000
) (
	input  logic               clock,
	input  logic               rst_i,
	input  logic               inst_ready_i,
	input  logic               inst_rvalid_i,
	input  rv_core_pkg::word_t inst_data_i,
	output logic               inst_req_o,
	output rv_core_pkg::word_t inst_addr_o,
	fetch_if.producer          fetch
);
	rv_core_pkg::fetch_state_e state_q;
	rv_core_pkg::word_t pc_q;
	rv_core_pkg::word_t buf_pc_q;
	rv_core_pkg::word_t buf_inst_q;
	logic req_q;
	logic accept;

	assign accept = req_q && inst_ready_i;
	assign inst_req_o = req_q;
	assign inst_addr_o = pc_q;

	assign fetch.valid = (state_q == rv_core_pkg::fetch_full);
	assign fetch.pc = buf_pc_q;
	assign fetch.inst = buf_inst_q;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			state_q <= rv_core_pkg::fetch_request;
			req_q <= 1'b0;
			pc_q <= RESET_PC;
		end else begin
			case (state_q)
				rv_core_pkg::fetch_request: begin
					// req_q is only low here in the first cycle out of reset
					req_q <= !accept;
					if (accept) begin
						state_q <= rv_core_pkg::fetch_wait;
						pc_q <= pc_q + 32'd4;
					end
				end
				rv_core_pkg::fetch_wait: begin
					if (inst_rvalid_i) begin
						state_q <= rv_core_pkg::fetch_full;
					end
				end
				rv_core_pkg::fetch_full: begin
					// buffer drains into decode, next request follows
					if (fetch.ready) begin
						state_q <= rv_core_pkg::fetch_request;
						req_q <= 1'b1;
					end
				end
				default: begin
					state_q <= rv_core_pkg::fetch_request;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			buf_pc_q <= pc_q;
		end
		if (state_q == rv_core_pkg::fetch_wait && inst_rvalid_i) begin
			buf_inst_q <= inst_data_i;
		end
	end

endmodule

//--- rtl/fetch_if.sv
`timescale 1ns/1ps

interface fetch_if;
	logic valid;
	logic ready;
	rv_core_pkg::word_t pc;
	rv_core_pkg::word_t inst;

	modport producer (
		output valid,
		output pc,
		output inst,
		input ready
	);

	modport consumer (
		input valid,
		input pc,
		input inst,
		output ready
	);
endinterface

//--- rtl/rv_core_pkg.sv
package rv_core_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_addr_t;
	typedef logic [xlen-1:0] word_t;

	// major opcodes handled by decode
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_system = 7'b1110011;
	localparam logic [31:0] ebreak_inst = 32'h0010_0073;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_e;

	// decode to execute
	typedef struct packed {
		word_t pc;
		alu_op_e op;
		word_t a;
		word_t b;
		reg_addr_t rd;
		logic we;
		logic ebreak;
	} issue_t;

	typedef struct packed {
		logic we;
		reg_addr_t rd;
		word_t data;
	} retire_t;

	typedef enum logic [1:0] {
		fetch_request,
		fetch_wait,
		fetch_full
	} fetch_state_e;

endpackage
